// File: all.f
design/cpu_pkg.sv
design/insn_decode.sv
design/insn_fetch.sv
design/reg_file.sv
design/stage_latch.sv
design/exec_unit.sv
design/cpu_core.sv
test/cpu_core_tb.sv

// File: design/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic [31:0] insn_data,
    input  wire logic [31:0] mem_rdata,
    output      logic [31:0] insn_addr,
    output      logic [31:0] mem_addr,
    output      logic [31:0] mem_wdata,
    output      logic        mem_we
);

    cpu_pkg::insn_t     insn_word;
    cpu_pkg::ctrl_t     ctrl;
    cpu_pkg::latch_t    d;
    cpu_pkg::latch_t    q;
    cpu_pkg::redirect_t redirect;
    logic [4:0]         rd_addr_a;
    logic [4:0]         rd_addr_b;
    logic [31:0]        rd_data_a;
    logic [31:0]        rd_data_b;
    logic               wr_en;
    logic [4:0]         wr_addr;
    logic [31:0]        wr_data;

    assign insn_word = insn_data;

    // stage 1, fetch and decode
    insn_fetch u_fetch (
        .clock(clock), .reset(reset), .redirect(redirect), .insn_addr(insn_addr)
    );

    insn_decode u_decode (
        .opcode(insn_word.r.opcode), .aluop(insn_word.r.aluop), .ctrl(ctrl)
    );

    // bex tests r30, rt_in swaps rd into slot b
    assign rd_addr_a = (insn_word.r.opcode == cpu_pkg::op_bex) ? cpu_pkg::reg_status
                                                               : insn_word.r.rs;
    assign rd_addr_b = ctrl.rt_in ? insn_word.r.rd : insn_word.r.rt;

    reg_file u_regs (
        .clock(clock), .reset(reset),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    always_comb begin
        d.valid  = 1'b1;
        d.pc     = insn_addr;
        d.insn   = insn_word;
        d.ctrl   = ctrl;
        d.rs_val = rd_data_a;
        d.rt_val = rd_data_b;
    end

    // taken redirect kills the instruction behind it
    stage_latch u_latch (
        .clock(clock), .reset(reset), .flush(redirect.taken), .d(d), .q(q)
    );

    // stage 2
    exec_unit u_exec (
        .q(q), .mem_rdata(mem_rdata),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .redirect(redirect)
    );

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // primary opcodes, instruction bits [31:27]
    localparam logic [4:0] op_add  = 5'd0;
    localparam logic [4:0] op_j    = 5'd1;
    localparam logic [4:0] op_bne  = 5'd2;
    localparam logic [4:0] op_jal  = 5'd3;
    localparam logic [4:0] op_jr   = 5'd4;
    localparam logic [4:0] op_addi = 5'd5;
    localparam logic [4:0] op_blt  = 5'd6;
    localparam logic [4:0] op_sw   = 5'd7;
    localparam logic [4:0] op_lw   = 5'd8;
    localparam logic [4:0] op_setx = 5'd21;
    localparam logic [4:0] op_bex  = 5'd22;

    // alu function codes, r-type bits [6:2]
    localparam logic [4:0] alu_add = 5'd0;
    localparam logic [4:0] alu_sub = 5'd1;
    localparam logic [4:0] alu_and = 5'd2;
    localparam logic [4:0] alu_or  = 5'd3;
    localparam logic [4:0] alu_sll = 5'd4;
    localparam logic [4:0] alu_sra = 5'd5;

    // fixed registers
    localparam logic [4:0] reg_link   = 5'd31;
    localparam logic [4:0] reg_status = 5'd30;

    typedef struct packed {
        logic [4:0] opcode;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] shamt;
        logic [4:0] aluop;
        logic [1:0] unused;
    } insn_r_t;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [16:0] imm;
    } insn_i_t;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [26:0] target;
    } insn_ji_t;

    // one instruction word, three field layouts
    typedef union packed {
        insn_r_t  r;
        insn_i_t  i;
        insn_ji_t ji;
    } insn_t;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc1,
        wb_target
    } wb_sel_t;

    typedef struct packed {
        wb_sel_t    wb_sel;
        logic       reg_we;
        logic       use_mem;
        logic       mem_we;
        logic       alu_imm;
        logic [4:0] alu_op;
        logic       rt_in;
        logic       jr;
        logic       branch;
        logic       jump;
        logic       jal;
        logic       setx;
    } ctrl_t;

    // everything stage 2 needs from stage 1
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        insn_t       insn;
        ctrl_t       ctrl;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
    } latch_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  wire cpu_pkg::latch_t    q,
    input  wire logic [31:0]        mem_rdata,
    output      logic [31:0]        mem_addr,
    output      logic [31:0]        mem_wdata,
    output      logic               mem_we,
    output      logic               wr_en,
    output      logic [4:0]         wr_addr,
    output      logic [31:0]        wr_data,
    output      cpu_pkg::redirect_t redirect
);

    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [32:0] diff;
    logic [31:0] alu_out;
    logic [31:0] pc_plus1;
    logic [31:0] jump_target;
    logic        rs_gt_rd;
    logic        cond;

    // 17-bit immediate, sign extended
    assign imm_ext = {{15{q.insn.i.imm[16]}}, q.insn.i.imm};
    assign alu_b   = q.ctrl.alu_imm ? imm_ext : q.rt_val;

    // 33-bit subtract keeps the true sign for compares
    assign diff = {q.rs_val[31], q.rs_val} - {alu_b[31], alu_b};

    always_comb begin
        case (q.ctrl.alu_op)
            cpu_pkg::alu_add: alu_out = q.rs_val + alu_b;
            cpu_pkg::alu_sub: alu_out = diff[31:0];
            cpu_pkg::alu_and: alu_out = q.rs_val & alu_b;
            cpu_pkg::alu_or:  alu_out = q.rs_val | alu_b;
            cpu_pkg::alu_sll: alu_out = q.rs_val << q.insn.r.shamt;
            cpu_pkg::alu_sra: alu_out = $signed(q.rs_val) >>> q.insn.r.shamt;
            default:          alu_out = '0;
        endcase
    end

    // rd < rs means rs - rd strictly positive
    assign rs_gt_rd = ~diff[32] & (|diff[31:0]);

    always_comb begin
        case (q.insn.r.opcode)
            cpu_pkg::op_bne: cond = |diff[31:0];
            cpu_pkg::op_blt: cond = rs_gt_rd;
            // rs slot holds r30 for bex
            cpu_pkg::op_bex: cond = |q.rs_val;
            default:         cond = 1'b0;
        endcase
    end

    assign pc_plus1    = q.pc + 32'd1;
    assign jump_target = {5'd0, q.insn.ji.target};

    always_comb begin
        redirect.taken = q.valid &
            (q.ctrl.jr | (q.ctrl.jump & ~q.ctrl.branch) | (q.ctrl.branch & cond));
        if (q.ctrl.jr) begin
            // jr returns to the rd value
            redirect.target = q.rt_val;
        end else if (q.ctrl.jump) begin
            redirect.target = jump_target;
        end else begin
            redirect.target = pc_plus1 + imm_ext;
        end
    end

    // data memory, address only driven on an access
    assign mem_addr  = (q.ctrl.use_mem | q.ctrl.mem_we) ? alu_out : '0;
    assign mem_wdata = q.rt_val;
    assign mem_we    = q.valid & q.ctrl.mem_we;

    // writeback
    assign wr_en = q.valid & q.ctrl.reg_we;

    always_comb begin
        if (q.ctrl.jal) begin
            wr_addr = cpu_pkg::reg_link;
        end else if (q.ctrl.setx) begin
            wr_addr = cpu_pkg::reg_status;
        end else begin
            wr_addr = q.insn.r.rd;
        end
        case (q.ctrl.wb_sel)
            cpu_pkg::wb_alu:    wr_data = alu_out;
            cpu_pkg::wb_mem:    wr_data = mem_rdata;
            cpu_pkg::wb_pc1:    wr_data = pc_plus1;
            cpu_pkg::wb_target: wr_data = jump_target;
            default:            wr_data = alu_out;
        endcase
    end

endmodule

`default_nettype wire

// File: design/insn_decode.sv
`timescale 1ns/1ns
`default_nettype none

module insn_decode (
    input  wire logic [4:0]    opcode,
    input  wire logic [4:0]    aluop,
    output cpu_pkg::ctrl_t     ctrl
);

    always_comb begin
        // unknown opcode falls out as a nop
        ctrl = '0;
        case (opcode)
            cpu_pkg::op_add: begin
                ctrl.wb_sel = cpu_pkg::wb_alu;
                ctrl.reg_we = 1'b1;
                // r-type uses its own function field
                ctrl.alu_op = aluop;
            end
            cpu_pkg::op_addi: begin
                ctrl.wb_sel  = cpu_pkg::wb_alu;
                ctrl.reg_we  = 1'b1;
                ctrl.alu_imm = 1'b1;
                ctrl.alu_op  = cpu_pkg::alu_add;
            end
            cpu_pkg::op_lw: begin
                ctrl.wb_sel  = cpu_pkg::wb_mem;
                ctrl.reg_we  = 1'b1;
                ctrl.use_mem = 1'b1;
                ctrl.alu_imm = 1'b1;
                ctrl.alu_op  = cpu_pkg::alu_add;
            end
            cpu_pkg::op_sw: begin
                ctrl.mem_we  = 1'b1;
                ctrl.alu_imm = 1'b1;
                ctrl.alu_op  = cpu_pkg::alu_add;
                // store data comes from rd
                ctrl.rt_in   = 1'b1;
            end
            cpu_pkg::op_bne,
            cpu_pkg::op_blt: begin
                // compare rs against rd via subtract
                ctrl.alu_op = cpu_pkg::alu_sub;
                ctrl.rt_in  = 1'b1;
                ctrl.branch = 1'b1;
            end
            cpu_pkg::op_j: begin
                ctrl.jump = 1'b1;
            end
            cpu_pkg::op_jal: begin
                ctrl.wb_sel = cpu_pkg::wb_pc1;
                ctrl.reg_we = 1'b1;
                ctrl.jump   = 1'b1;
                ctrl.jal    = 1'b1;
            end
            cpu_pkg::op_jr: begin
                // return address read through the rt slot
                ctrl.rt_in = 1'b1;
                ctrl.jr    = 1'b1;
            end
            cpu_pkg::op_setx: begin
                ctrl.wb_sel = cpu_pkg::wb_target;
                ctrl.reg_we = 1'b1;
                ctrl.setx   = 1'b1;
            end
            cpu_pkg::op_bex: begin
                // conditional on r30, absolute target
                ctrl.branch = 1'b1;
                ctrl.jump   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/insn_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module insn_fetch (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire cpu_pkg::redirect_t redirect,
    output      logic [31:0]        insn_addr
);

    logic [31:0] pc;
    logic [31:0] pc_next;

    // taken branch or jump wins over sequential
    always_comb begin
        if (redirect.taken) begin
            pc_next = redirect.target;
        end else begin
            pc_next = pc + 32'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // word address straight to instruction memory
    // also the pc captured into the stage latch
    assign insn_addr = pc;

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic [4:0]  rd_addr_a,
    input  wire logic [4:0]  rd_addr_b,
    output      logic [31:0] rd_data_a,
    output      logic [31:0] rd_data_b,
    input  wire logic        wr_en,
    input  wire logic [4:0]  wr_addr,
    input  wire logic [31:0] wr_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 reads zero, same-cycle write bypasses the array
    always_comb begin
        if (rd_addr_a == 5'd0) begin
            rd_data_a = '0;
        end else if (wr_en && wr_addr == rd_addr_a) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end
        if (rd_addr_b == 5'd0) begin
            rd_data_b = '0;
        end else if (wr_en && wr_addr == rd_addr_b) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

endmodule

`default_nettype wire

// File: design/stage_latch.sv
`timescale 1ns/1ns
`default_nettype none

module stage_latch (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            flush,
    input  wire cpu_pkg::latch_t d,
    output      cpu_pkg::latch_t q
);

    // valid bit, the only control state here
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            q.valid <= 1'b0;
        end else begin
            q.valid <= d.valid;
        end
    end

    // payload follows every cycle
    // stale fields behind valid low are harmless
    always_ff @(posedge clock) begin
        q.pc     <= d.pc;
        q.insn   <= d.insn;
        q.ctrl   <= d.ctrl;
        q.rs_val <= d.rs_val;
        q.rt_val <= d.rt_val;
    end

endmodule

`default_nettype wire

// File: test/cpu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;

    localparam logic [31:0] marker = 32'd255;

    logic        clock;
    logic        reset;
    logic [31:0] insn_data;
    logic [31:0] mem_rdata;
    logic [31:0] insn_addr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    int          load_ptr;
    int          errors;
    int          errs_before;
    int          tests;
    int          seed;
    string       cur_test;

    cpu_core UUT (
        .clock(clock), .reset(reset), .insn_data(insn_data), .mem_rdata(mem_rdata),
        .insn_addr(insn_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we)
    );

    // both memories answer in the same cycle
    assign insn_data = imem[insn_addr[7:0]];
    assign mem_rdata = dmem[mem_addr[7:0]];

    always @(posedge clock) begin
        if (mem_we) begin
            dmem[mem_addr[7:0]] <= mem_wdata;
        end
    end

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // instruction encoders
    function automatic logic [31:0] r_word(input logic [4:0] rd, rs, rt, shamt, func);
        return {cpu_pkg::op_add, rd, rs, rt, shamt, func, 2'b00};
    endfunction

    function automatic logic [31:0] i_word(input logic [4:0] op, rd, rs,
                                           input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [31:0] ji_word(input logic [4:0] op, input logic [26:0] target);
        return {op, target};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[load_ptr] = word;
        load_ptr++;
    endtask

    // reset held from here
    // memories wiped once the core is quiet
    task automatic begin_test(input string name);
        cur_test    = name;
        errs_before = errors;
        load_ptr    = 0;
        reset       = 1'b1;
        @(negedge clock);
        for (int a = 0; a < 256; a++) begin
            imem[a] = '0;
            dmem[a] = '0;
        end
    endtask

    task automatic release_reset();
        repeat (4) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic wait_marker();
        int  n;
        logic hit;
        hit = 1'b0;
        for (n = 0; n < 200 && !hit; n++) begin
            @(negedge clock);
            if (mem_we && mem_addr == marker) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            $display("%s: program never reached its final store", cur_test);
            errors++;
        end else begin
            // let the marker store land
            @(negedge clock);
        end
    endtask

    task automatic end_test();
        tests++;
        $display("test %s finished with %0d errors", cur_test, errors - errs_before);
    endtask

    task automatic reset_state();
        begin_test("reset");
        // every word is a store to a spare address
        // mem_we stays low only while nothing valid sits in the latch
        for (int a = 0; a < 256; a++) begin
            emit(i_word(cpu_pkg::op_sw, 5'd0, 5'd0, 17'd200));
        end
        repeat (4) begin
            @(negedge clock);
            check_value("mem_we in reset", 32'd0, {31'd0, mem_we});
            check_value("insn_addr in reset", 32'd0, insn_addr);
        end
        reset = 1'b0;
        for (int k = 1; k <= 4; k++) begin
            @(negedge clock);
            check_value("insn_addr step", k, insn_addr);
            // the store fetched one cycle earlier is now in stage 2
            check_value("mem_we after reset", 32'd1, {31'd0, mem_we});
        end
        end_test();
    endtask

    task automatic alu_chain();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [4:0]  sh2;
        logic [31:0] e [6];
        begin_test("alu");
        a   = {{15{1'b0}}, 17'($random(seed))};
        a   = {{15{a[16]}}, a[16:0]};
        b   = {{15{1'b0}}, 17'($random(seed))};
        b   = {{15{b[16]}}, b[16:0]};
        sh  = 5'($random(seed));
        sh2 = 5'($random(seed));
        emit(i_word(cpu_pkg::op_addi, 5'd1, 5'd0, a[16:0]));
        emit(i_word(cpu_pkg::op_addi, 5'd2, 5'd0, b[16:0]));
        // each result feeds the next one straight away
        emit(r_word(5'd3, 5'd1, 5'd2, 5'd0, cpu_pkg::alu_add));
        emit(r_word(5'd4, 5'd3, 5'd2, 5'd0, cpu_pkg::alu_sub));
        emit(r_word(5'd5, 5'd4, 5'd2, 5'd0, cpu_pkg::alu_and));
        emit(r_word(5'd6, 5'd5, 5'd1, 5'd0, cpu_pkg::alu_or));
        emit(r_word(5'd7, 5'd6, 5'd0, sh, cpu_pkg::alu_sll));
        emit(r_word(5'd8, 5'd7, 5'd0, sh2, cpu_pkg::alu_sra));
        for (int r = 0; r < 6; r++) begin
            emit(i_word(cpu_pkg::op_sw, 5'(r + 3), 5'd0, 17'(r)));
        end
        emit(i_word(cpu_pkg::op_sw, 5'd0, 5'd0, marker[16:0]));
        e[0] = a + b;
        e[1] = e[0] - b;
        e[2] = e[1] & b;
        e[3] = e[2] | a;
        e[4] = e[3] << sh;
        e[5] = $signed(e[4]) >>> sh2;
        release_reset();
        wait_marker();
        for (int r = 0; r < 6; r++) begin
            check_value($sformatf("result %0d", r), e[r], dmem[r]);
        end
        end_test();
    endtask

    task automatic store_load_copy();
        logic [31:0] w;
        begin_test("memory");
        w = $random(seed);
        emit(i_word(cpu_pkg::op_addi, 5'd1, 5'd0, 17'd10));
        // build the full word from two halves
        emit(i_word(cpu_pkg::op_addi, 5'd2, 5'd0, {1'b0, w[31:16]}));
        emit(r_word(5'd2, 5'd2, 5'd0, 5'd16, cpu_pkg::alu_sll));
        emit(i_word(cpu_pkg::op_addi, 5'd3, 5'd0, {1'b0, w[15:0]}));
        emit(r_word(5'd2, 5'd2, 5'd3, 5'd0, cpu_pkg::alu_or));
        emit(i_word(cpu_pkg::op_sw, 5'd2, 5'd1, 17'd0));
        emit(i_word(cpu_pkg::op_lw, 5'd4, 5'd1, 17'd0));
        emit(i_word(cpu_pkg::op_sw, 5'd4, 5'd1, 17'd5));
        emit(i_word(cpu_pkg::op_sw, 5'd0, 5'd0, marker[16:0]));
        release_reset();
        wait_marker();
        check_value("first store", w, dmem[10]);
        check_value("copy after load", w, dmem[15]);
        end_test();
    endtask

    task automatic branch_paths();
        begin_test("branches");
        emit(i_word(cpu_pkg::op_addi, 5'd1, 5'd0, 17'd5));
        emit(i_word(cpu_pkg::op_addi, 5'd2, 5'd0, 17'd9));
        emit(i_word(cpu_pkg::op_addi, 5'd3, 5'd0, 17'd1));
        emit(i_word(cpu_pkg::op_addi, 5'd4, 5'd0, 17'd2));
        emit(i_word(cpu_pkg::op_addi, 5'd5, 5'd0, 17'd7));
        emit(i_word(cpu_pkg::op_addi, 5'd6, 5'd0, -17'sd3));
        // bne on equal values falls through
        emit(i_word(cpu_pkg::op_bne, 5'd1, 5'd1, 17'd1));
        emit(i_word(cpu_pkg::op_sw, 5'd3, 5'd0, 17'd20));
        // bne on different values skips one
        emit(i_word(cpu_pkg::op_bne, 5'd1, 5'd2, 17'd1));
        emit(i_word(cpu_pkg::op_sw, 5'd5, 5'd0, 17'd21));
        emit(i_word(cpu_pkg::op_sw, 5'd4, 5'd0, 17'd22));
        // blt 9 < 5 is false
        emit(i_word(cpu_pkg::op_blt, 5'd2, 5'd1, 17'd1));
        emit(i_word(cpu_pkg::op_sw, 5'd3, 5'd0, 17'd23));
        emit(i_word(cpu_pkg::op_blt, 5'd1, 5'd2, 17'd1));
        emit(i_word(cpu_pkg::op_sw, 5'd5, 5'd0, 17'd24));
        emit(i_word(cpu_pkg::op_sw, 5'd4, 5'd0, 17'd25));
        // signed compare of -3 against 5
        emit(i_word(cpu_pkg::op_blt, 5'd6, 5'd1, 17'd1));
        emit(i_word(cpu_pkg::op_sw, 5'd5, 5'd0, 17'd26));
        emit(i_word(cpu_pkg::op_sw, 5'd4, 5'd0, 17'd27));
        emit(i_word(cpu_pkg::op_sw, 5'd0, 5'd0, marker[16:0]));
        release_reset();
        wait_marker();
        check_value("bne not taken", 32'd1, dmem[20]);
        check_value("bne shadow", 32'd0, dmem[21]);
        check_value("bne taken", 32'd2, dmem[22]);
        check_value("blt not taken", 32'd1, dmem[23]);
        check_value("blt shadow", 32'd0, dmem[24]);
        check_value("blt taken", 32'd2, dmem[25]);
        check_value("blt signed shadow", 32'd0, dmem[26]);
        check_value("blt signed taken", 32'd2, dmem[27]);
        end_test();
    endtask

    task automatic jump_and_return();
        begin_test("jumps");
        emit(i_word(cpu_pkg::op_addi, 5'd3, 5'd0, 17'd1));
        emit(i_word(cpu_pkg::op_addi, 5'd4, 5'd0, 17'd2));
        emit(ji_word(cpu_pkg::op_j, 27'd4));
        emit(i_word(cpu_pkg::op_sw, 5'd3, 5'd0, 17'd30));
        // call at 4 returns to 5
        emit(ji_word(cpu_pkg::op_jal, 27'd8));
        emit(i_word(cpu_pkg::op_sw, 5'd31, 5'd0, 17'd32));
        emit(i_word(cpu_pkg::op_sw, 5'd0, 5'd0, marker[16:0]));
        emit(32'd0);
        emit(i_word(cpu_pkg::op_sw, 5'd4, 5'd0, 17'd31));
        emit(i_word(cpu_pkg::op_jr, 5'd31, 5'd0, 17'd0));
        emit(i_word(cpu_pkg::op_sw, 5'd3, 5'd0, 17'd33));
        release_reset();
        wait_marker();
        check_value("j skipped store", 32'd0, dmem[30]);
        check_value("subroutine store", 32'd2, dmem[31]);
        check_value("link register", 32'd5, dmem[32]);
        check_value("jr shadow", 32'd0, dmem[33]);
        end_test();
    endtask

    task automatic status_branch();
        begin_test("setx_bex");
        emit(i_word(cpu_pkg::op_addi, 5'd3, 5'd0, 17'd1));
        emit(i_word(cpu_pkg::op_addi, 5'd4, 5'd0, 17'd2));
        emit(ji_word(cpu_pkg::op_setx, 27'd12));
        emit(ji_word(cpu_pkg::op_bex, 27'd6));
        emit(i_word(cpu_pkg::op_sw, 5'd3, 5'd0, 17'd40));
        emit(i_word(cpu_pkg::op_sw, 5'd3, 5'd0, 17'd41));
        emit(i_word(cpu_pkg::op_sw, 5'd4, 5'd0, 17'd42));
        // cleared status makes bex fall through
        emit(ji_word(cpu_pkg::op_setx, 27'd0));
        emit(ji_word(cpu_pkg::op_bex, 27'd11));
        emit(i_word(cpu_pkg::op_sw, 5'd3, 5'd0, 17'd43));
        emit(ji_word(cpu_pkg::op_j, 27'd12));
        emit(i_word(cpu_pkg::op_sw, 5'd4, 5'd0, 17'd44));
        emit(i_word(cpu_pkg::op_sw, 5'd0, 5'd0, marker[16:0]));
        release_reset();
        wait_marker();
        check_value("bex shadow", 32'd0, dmem[40]);
        check_value("bex skipped", 32'd0, dmem[41]);
        check_value("bex taken", 32'd2, dmem[42]);
        check_value("bex not taken", 32'd1, dmem[43]);
        check_value("bex wrong path", 32'd0, dmem[44]);
        end_test();
    endtask

    initial begin
        reset    = 1'b1;
        errors   = 0;
        tests    = 0;
        load_ptr = 0;
        seed     = 32'hcd53_1aa6;
        for (int a = 0; a < 256; a++) begin
            imem[a] = '0;
            dmem[a] = '0;
        end
        reset_state();
        alu_chain();
        store_load_copy();
        branch_paths();
        jump_and_return();
        status_branch();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
